//--- common/rv_core_pkg.sv
package rv_core_pkg;

    // ====================
    // widths
    // ====================
    parameter int xlen = 32;

    typedef logic [xlen-1:0] xword_t;
    typedef logic [4:0]      reg_idx_t;

    // ====================
    // instruction word views
    // ====================
    // the same 32 bits, read by format
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r_fmt;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i_fmt;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_fmt;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u_fmt;
    } instr_u;

    // ====================
    // decoded kinds
    // ====================
    typedef enum logic [3:0] {
        grp_lui, grp_auipc, grp_jal, grp_jalr, grp_branch,
        grp_load, grp_store, grp_alu_imm, grp_alu_reg, grp_nop
    } op_group_e;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu,
        alu_xor, alu_srl, alu_sra, alu_or, alu_and
    } alu_op_e;

    // length code seen by the memory
    typedef enum logic [1:0] {
        read_32, write_8, write_16, write_32
    } bus_len_e;

    // access size, from funct3[1:0]
    typedef enum logic [1:0] {
        size_byte, size_half, size_word
    } mem_size_e;

endpackage

//--- hw/rv_decoder.sv
`timescale 1ns/100ps

module rv_decoder import rv_core_pkg::*; (
    input  instr_u     instr,
    output reg_idx_t   rs1_idx,
    output reg_idx_t   rs2_idx,
    output reg_idx_t   rd_idx,
    output op_group_e  group,
    output logic [2:0] funct3,
    output logic       funct7_5,
    output xword_t     imm
);

    // base opcodes
    localparam logic [6:0] opc_lui     = 7'b0110111;
    localparam logic [6:0] opc_auipc   = 7'b0010111;
    localparam logic [6:0] opc_jal     = 7'b1101111;
    localparam logic [6:0] opc_jalr    = 7'b1100111;
    localparam logic [6:0] opc_branch  = 7'b1100011;
    localparam logic [6:0] opc_load    = 7'b0000011;
    localparam logic [6:0] opc_store   = 7'b0100011;
    localparam logic [6:0] opc_alu_imm = 7'b0010011;
    localparam logic [6:0] opc_alu_reg = 7'b0110011;

    assign rs1_idx  = instr.r_fmt.rs1;
    assign rs2_idx  = instr.s_fmt.rs2;
    assign rd_idx   = instr.u_fmt.rd;
    assign funct3   = instr.i_fmt.funct3;
    assign funct7_5 = instr.r_fmt.funct7[5];

    always_comb begin
        case (instr.r_fmt.opcode)
            opc_lui:     group = grp_lui;
            opc_auipc:   group = grp_auipc;
            opc_jal:     group = grp_jal;
            opc_jalr:    group = grp_jalr;
            opc_branch:  group = grp_branch;
            opc_load:    group = grp_load;
            opc_store:   group = grp_store;
            opc_alu_imm: group = grp_alu_imm;
            opc_alu_reg: group = grp_alu_reg;
            // fence and anything unknown
            default:     group = grp_nop;
        endcase
    end

    // immediate by format, always sign extended from bit 31
    always_comb begin
        case (group)
            grp_alu_imm, grp_load, grp_jalr:
                imm = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
            grp_store:
                imm = {{20{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi, instr.s_fmt.imm_lo};
            grp_branch:
                imm = {{19{instr.s_fmt.imm_hi[6]}}, instr.s_fmt.imm_hi[6],
                       instr.s_fmt.imm_lo[0], instr.s_fmt.imm_hi[5:0],
                       instr.s_fmt.imm_lo[4:1], 1'b0};
            grp_lui, grp_auipc:
                imm = {instr.u_fmt.imm, 12'b0};
            grp_jal:
                imm = {{11{instr.u_fmt.imm[19]}}, instr.u_fmt.imm[19],
                       instr.u_fmt.imm[7:0], instr.u_fmt.imm[8],
                       instr.u_fmt.imm[18:9], 1'b0};
            default:
                imm = '0;
        endcase
    end

endmodule

//--- hw/reg_file.sv
`timescale 1ns/100ps

module reg_file import rv_core_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  reg_idx_t rs1_idx,
    input  reg_idx_t rs2_idx,
    input  reg_idx_t rd_idx,
    input  logic     rd_wen,
    input  xword_t   rd_dat,
    output xword_t   rs1_dat,
    output xword_t   rs2_dat
);

    // x0 has no storage
    xword_t regs [1:31];

    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_wen && rd_idx != 5'd0) begin
            regs[rd_idx] <= rd_dat;
        end
    end

    assign rs1_dat = (rs1_idx == 5'd0) ? '0 : regs[rs1_idx];
    assign rs2_dat = (rs2_idx == 5'd0) ? '0 : regs[rs2_idx];

endmodule

//--- hw/rv_alu.sv
`timescale 1ns/100ps

module rv_alu import rv_core_pkg::*; (
    input  xword_t  a,
    input  xword_t  b,
    input  alu_op_e op,
    output xword_t  result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    // only five bits of shift amount matter
    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            alu_add:  result = a + b;
            alu_sub:  result = a - b;
            alu_sll:  result = a << shamt;
            alu_srl:  result = a >> shamt;
            alu_sra:  result = $signed(a) >>> shamt;
            // compares give 0 or 1
            alu_slt:  result = {{(xlen-1){1'b0}}, lt_signed};
            alu_sltu: result = {{(xlen-1){1'b0}}, lt_unsigned};
            alu_xor:  result = a ^ b;
            alu_or:   result = a | b;
            alu_and:  result = a & b;
            default:  result = '0;
        endcase
    end

endmodule

//--- hw/mem_access.sv
`timescale 1ns/100ps

module mem_access import rv_core_pkg::*; (
    input  logic      clk_cpu,
    input  logic      rst_n,
    input  logic      mem_start,
    input  xword_t    mem_addr,
    input  mem_size_e mem_size,
    input  logic      mem_write,
    input  logic      mem_signed,
    input  xword_t    mem_wdata,
    input  logic      bus_ready,
    input  xword_t    bus_rdata,
    output logic      mem_done,
    output xword_t    mem_rdata,
    output logic      bus_req,
    output xword_t    bus_addr,
    output xword_t    bus_wdata,
    output bus_len_e  bus_len
);

    logic      busy_q;
    mem_size_e size_q;
    logic      signed_q;
    logic [7:0]  lane_b;
    logic [15:0] lane_h;

    // ====================
    // request side
    // ====================
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            bus_req <= 1'b0;
            busy_q  <= 1'b0;
        end else begin
            bus_req <= mem_start;
            if (mem_start) begin
                busy_q <= 1'b1;
            end else if (bus_ready) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (mem_start) begin
            bus_addr <= mem_addr;
            size_q   <= mem_size;
            signed_q <= mem_signed;
            case (mem_size)
                size_byte: bus_wdata <= {4{mem_wdata[7:0]}};
                size_half: bus_wdata <= {2{mem_wdata[15:0]}};
                default:   bus_wdata <= mem_wdata;
            endcase
            if (!mem_write) begin
                bus_len <= read_32;
            end else begin
                case (mem_size)
                    size_byte: bus_len <= write_8;
                    size_half: bus_len <= write_16;
                    default:   bus_len <= write_32;
                endcase
            end
        end
    end

    // ====================
    // response side
    // ====================
    assign mem_done = busy_q & bus_ready;

    // pick lane by low address bits
    assign lane_b = bus_rdata[bus_addr[1:0]*8 +: 8];
    assign lane_h = bus_addr[1] ? bus_rdata[31:16] : bus_rdata[15:0];

    always_comb begin
        case (size_q)
            size_byte: mem_rdata = {{24{signed_q & lane_b[7]}}, lane_b};
            size_half: mem_rdata = {{16{signed_q & lane_h[15]}}, lane_h};
            default:   mem_rdata = bus_rdata;
        endcase
    end

endmodule

//--- core/rv_control.sv
`timescale 1ns/100ps

module rv_control import rv_core_pkg::*; #(
    parameter xword_t reset_pc = '0
) (
    input  logic       clk_cpu,
    input  logic       rst_n,
    input  op_group_e  group,
    input  logic [2:0] funct3,
    input  logic       funct7_5,
    input  xword_t     imm,
    input  xword_t     rs1_dat,
    input  xword_t     rs2_dat,
    input  xword_t     alu_result,
    input  logic       mem_done,
    input  xword_t     mem_rdata,
    output instr_u     instr_q,
    output xword_t     alu_a,
    output xword_t     alu_b,
    output alu_op_e    alu_op,
    output logic       rd_wen,
    output xword_t     rd_dat,
    output logic       mem_start,
    output xword_t     mem_addr,
    output mem_size_e  mem_size,
    output logic       mem_write,
    output logic       mem_signed,
    output xword_t     mem_wdata
);

    localparam logic [2:0] st_fetch      = 3'd0;
    localparam logic [2:0] st_fetch_wait = 3'd1;
    localparam logic [2:0] st_execute    = 3'd2;
    localparam logic [2:0] st_data_wait  = 3'd3;
    localparam logic [2:0] st_writeback  = 3'd4;

    logic [2:0] state;
    xword_t     pc;
    xword_t     pc_next_q;
    xword_t     next_pc;
    xword_t     wb_val;
    xword_t     op_b;
    logic       is_alu;
    logic       is_data;
    logic       writes_rd;
    logic       branch_taken;

    assign is_alu    = (group == grp_alu_imm) || (group == grp_alu_reg);
    assign is_data   = (group == grp_load) || (group == grp_store);
    assign writes_rd = !(group == grp_branch || group == grp_store || group == grp_nop);

    // ====================
    // operand and op select
    // ====================
    assign alu_a = rs1_dat;
    assign op_b  = (group == grp_alu_reg) ? rs2_dat : imm;
    assign alu_b = (is_alu && funct3[1:0] == 2'b01) ? {{(xlen-5){1'b0}}, op_b[4:0]} : op_b;

    always_comb begin
        alu_op = alu_add;
        if (is_alu) begin
            case (funct3)
                3'b000: alu_op = (group == grp_alu_reg && funct7_5) ? alu_sub : alu_add;
                3'b001: alu_op = alu_sll;
                3'b010: alu_op = alu_slt;
                3'b011: alu_op = alu_sltu;
                3'b100: alu_op = alu_xor;
                3'b101: alu_op = funct7_5 ? alu_sra : alu_srl;
                3'b110: alu_op = alu_or;
                default: alu_op = alu_and;
            endcase
        end
    end

    always_comb begin
        case (funct3)
            3'b000:  branch_taken = (rs1_dat == rs2_dat);
            3'b001:  branch_taken = (rs1_dat != rs2_dat);
            3'b100:  branch_taken = ($signed(rs1_dat) < $signed(rs2_dat));
            3'b101:  branch_taken = ($signed(rs1_dat) >= $signed(rs2_dat));
            3'b110:  branch_taken = (rs1_dat < rs2_dat);
            3'b111:  branch_taken = (rs1_dat >= rs2_dat);
            default: branch_taken = 1'b0;
        endcase
    end

    // next pc and write-back value
    always_comb begin
        next_pc = pc + 32'd4;
        wb_val  = alu_result;
        case (group)
            grp_lui:    wb_val = imm;
            grp_auipc:  wb_val = pc + imm;
            grp_jal: begin
                wb_val  = pc + 32'd4;
                next_pc = pc + imm;
            end
            grp_jalr: begin
                wb_val  = pc + 32'd4;
                next_pc = (rs1_dat + imm) & ~32'd1;
            end
            grp_branch: begin
                if (branch_taken) begin
                    next_pc = pc + imm;
                end
            end
            default: ;
        endcase
    end

    // fetch in st_fetch, data access out of execute
    always_comb begin
        mem_start  = (state == st_fetch);
        mem_addr   = pc;
        mem_size   = size_word;
        mem_write  = 1'b0;
        mem_signed = 1'b0;
        mem_wdata  = rs2_dat;
        if (state == st_execute && is_data) begin
            mem_start  = 1'b1;
            mem_addr   = alu_result;
            mem_write  = (group == grp_store);
            mem_signed = !funct3[2];
            case (funct3[1:0])
                2'b00:   mem_size = size_byte;
                2'b01:   mem_size = size_half;
                default: mem_size = size_word;
            endcase
        end
    end

    assign rd_wen = (state == st_writeback) && writes_rd;

    // ====================
    // state machine
    // ====================
    always_ff @(posedge clk_cpu) begin
        if (!rst_n) begin
            state <= st_fetch;
            pc    <= reset_pc;
        end else begin
            case (state)
                st_fetch:      state <= st_fetch_wait;
                st_fetch_wait: if (mem_done) state <= st_execute;
                st_execute:    state <= is_data ? st_data_wait : st_writeback;
                st_data_wait:  if (mem_done) state <= st_writeback;
                st_writeback: begin
                    pc    <= pc_next_q;
                    state <= st_fetch;
                end
                default:       state <= st_fetch;
            endcase
        end
    end

    always_ff @(posedge clk_cpu) begin
        if (state == st_fetch_wait && mem_done) begin
            instr_q <= mem_rdata;
        end
        if (state == st_execute) begin
            pc_next_q <= next_pc;
            rd_dat    <= wb_val;
        end
        // load data replaces the alu address
        if (state == st_data_wait && mem_done) begin
            rd_dat <= mem_rdata;
        end
    end

endmodule

//--- core/rv_core.sv
`timescale 1ns/100ps

module rv_core import rv_core_pkg::*; #(
    parameter xword_t reset_pc = '0
) (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     bus_ready,
    input  xword_t   bus_rdata,
    output logic     bus_req,
    output xword_t   bus_addr,
    output xword_t   bus_wdata,
    output bus_len_e bus_len
);

    instr_u     instr_q;
    reg_idx_t   rs1_idx;
    reg_idx_t   rs2_idx;
    reg_idx_t   rd_idx;
    op_group_e  group;
    logic [2:0] funct3;
    logic       funct7_5;
    xword_t     imm;
    xword_t     rs1_dat;
    xword_t     rs2_dat;
    xword_t     rd_dat;
    logic       rd_wen;
    xword_t     alu_a;
    xword_t     alu_b;
    alu_op_e    alu_op;
    xword_t     alu_result;
    logic       mem_start;
    xword_t     mem_addr;
    mem_size_e  mem_size;
    logic       mem_write;
    logic       mem_signed;
    xword_t     mem_wdata;
    logic       mem_done;
    xword_t     mem_rdata;

    rv_control #(.reset_pc(reset_pc)) i_rv_control (
        .clk_cpu, .rst_n, .group, .funct3, .funct7_5, .imm, .rs1_dat, .rs2_dat,
        .alu_result, .mem_done, .mem_rdata, .instr_q, .alu_a, .alu_b, .alu_op,
        .rd_wen, .rd_dat, .mem_start, .mem_addr, .mem_size, .mem_write,
        .mem_signed, .mem_wdata
    );

    rv_decoder i_rv_decoder (
        .instr(instr_q), .rs1_idx, .rs2_idx, .rd_idx, .group, .funct3, .funct7_5, .imm
    );

    reg_file i_reg_file (
        .clk_cpu, .rst_n, .rs1_idx, .rs2_idx, .rd_idx, .rd_wen, .rd_dat, .rs1_dat, .rs2_dat
    );

    rv_alu i_rv_alu (.a(alu_a), .b(alu_b), .op(alu_op), .result(alu_result));

    mem_access i_mem_access (
        .clk_cpu, .rst_n, .mem_start, .mem_addr, .mem_size, .mem_write, .mem_signed,
        .mem_wdata, .bus_ready, .bus_rdata, .mem_done, .mem_rdata, .bus_req,
        .bus_addr, .bus_wdata, .bus_len
    );

endmodule

//--- verif/tb_mem_model.sv
`timescale 1ns/100ps

module tb_mem_model import rv_core_pkg::*; (
    input  logic     clk_cpu,
    input  logic     rst_n,
    input  logic     bus_req,
    input  xword_t   bus_addr,
    input  xword_t   bus_wdata,
    input  bus_len_e bus_len,
    input  int       fixed_lat,
    output logic     bus_ready,
    output xword_t   bus_rdata
);

    // 4 KB, one entry per aligned word
    xword_t   mem [0:1023];
    integer   seed = 32'h991d_f81c;
    logic     pending;
    int       count;
    xword_t   addr_q;
    xword_t   wdata_q;
    bus_len_e len_q;

    initial begin
        bus_ready = 1'b0;
        bus_rdata = '0;
        pending   = 1'b0;
    end

    // ====================
    // request and answer
    // ====================
    always @(posedge clk_cpu) begin
        #0.5;
        bus_ready = 1'b0;
        if (!rst_n) begin
            pending = 1'b0;
        end else if (pending) begin
            count = count - 1;
            if (count == 0) begin
                pending   = 1'b0;
                bus_ready = 1'b1;
                bus_rdata = mem[addr_q[11:2]];
                // only the lanes named by address and length
                case (len_q)
                    write_8:  mem[addr_q[11:2]][8*addr_q[1:0] +: 8] =
                                  wdata_q[8*addr_q[1:0] +: 8];
                    write_16: mem[addr_q[11:2]][16*addr_q[1] +: 16] =
                                  wdata_q[16*addr_q[1] +: 16];
                    write_32: mem[addr_q[11:2]] = wdata_q;
                    default: ;
                endcase
            end
        end else if (bus_req) begin
            addr_q  = bus_addr;
            wdata_q = bus_wdata;
            len_q   = bus_len;
            // latency 1 to 5 unless fixed
            count   = (fixed_lat > 0) ? fixed_lat : 1 + ($unsigned($random(seed)) % 5);
            pending = 1'b1;
        end
    end

endmodule

//--- verif/tb_rv_core.sv
`timescale 1ns/100ps

module tb_rv_core;
    import rv_core_pkg::*;

    localparam xword_t reset_pc      = 32'h0;
    localparam int     n_tests       = 6;
    localparam int     timeout_limit = n_tests * 2000;
    localparam xword_t data_base     = 32'h400;

    logic     clk_cpu = 1'b0;
    logic     rst_n;
    logic     bus_ready;
    xword_t   bus_rdata;
    logic     bus_req;
    xword_t   bus_addr;
    xword_t   bus_wdata;
    bus_len_e bus_len;
    int       fixed_lat;

    int       errors = 0;
    int       cycles = 0;
    int       fetch_count;
    logic     loop_seen;
    logic     have_last;
    logic     first_req;
    xword_t   last_fetch;

    xword_t   prog[$];
    xword_t   exp_vals[$];
    xword_t   exp_addr[$];
    xword_t   pre_addr[$];
    xword_t   pre_val[$];
    bus_len_e seen_lens[$];
    bus_len_e exp_lens[$];
    xword_t   seen_wdata[$];
    xword_t   exp_wdata[$];
    xword_t   saved[$];

    rv_core #(.reset_pc(reset_pc)) i_rv_core (
        .clk_cpu, .rst_n, .bus_ready, .bus_rdata, .bus_req, .bus_addr, .bus_wdata, .bus_len
    );

    tb_mem_model i_mem (
        .clk_cpu, .rst_n, .bus_req, .bus_addr, .bus_wdata, .bus_len, .fixed_lat,
        .bus_ready, .bus_rdata
    );

    always #2 clk_cpu = ~clk_cpu;

    always @(posedge clk_cpu) begin
        cycles = cycles + 1;
        if (cycles >= timeout_limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    // ====================
    // bus monitor
    // ====================
    always @(negedge clk_cpu) begin
        if (rst_n && bus_req) begin
            if (first_req) begin
                check_word("bus_addr", bus_addr, reset_pc);
                first_req = 1'b0;
            end
            if (bus_len != read_32) begin
                seen_lens.push_back(bus_len);
                seen_wdata.push_back(bus_wdata);
            end else if (bus_addr < data_base) begin
                if (bus_addr[1:0] != 2'b00) begin
                    $display("fetch from unaligned address %h at %0t", bus_addr, $time);
                    errors++;
                end
                // same address twice in a row is the closing self loop
                if (have_last && bus_addr == last_fetch) begin
                    loop_seen = 1'b1;
                end
                last_fetch  = bus_addr;
                have_last   = 1'b1;
                fetch_count = fetch_count + 1;
            end
        end
    end

    task automatic check_word(input string name, input xword_t got, input xword_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_len(input string name, input bus_len_e got, input bus_len_e exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %s expected %s", $time, name,
                     got.name(), exp.name());
            errors++;
        end
    endtask

    // instruction encoders
    function automatic xword_t enc_r(logic [6:0] f7, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3, reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic xword_t enc_i(logic [11:0] imm, reg_idx_t rs1, logic [2:0] f3,
                                     reg_idx_t rd, logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic xword_t enc_s(xword_t imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic xword_t enc_b(xword_t imm, reg_idx_t rs2, reg_idx_t rs1,
                                     logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic xword_t enc_j(xword_t imm, reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    function automatic xword_t fill_word(int idx);
        xword_t i;
        i = idx;
        return (i * 32'h9e37_79b9) ^ {i[15:0], ~i[15:0]};
    endfunction

    // ====================
    // program building
    // ====================
    function automatic xword_t pc_now();
        return prog.size() * 4;
    endfunction

    task automatic emit(input xword_t w);
        prog.push_back(w);
    endtask

    task automatic load_imm(input reg_idx_t rd, input xword_t v);
        xword_t hi;
        hi = (v + 32'h800) >> 12;
        emit({hi[19:0], rd, 7'h37});
        emit(enc_i(v[11:0], rd, 3'b000, rd, 7'h13));
    endtask

    task automatic store_expect(input reg_idx_t rs, input xword_t e);
        xword_t off;
        off = exp_vals.size() * 4;
        emit(enc_s(off, rs, 5'd10, 3'b010));
        exp_vals.push_back(e);
        exp_addr.push_back(data_base + off);
    endtask

    // one instruction, then its result stored for checking
    task automatic emit_and_store(input xword_t w, input reg_idx_t rd, input xword_t e);
        emit(w);
        store_expect(rd, e);
    endtask

    task automatic new_program();
        prog.delete();
        exp_vals.delete();
        exp_addr.delete();
        pre_addr.delete();
        pre_val.delete();
        exp_lens.delete();
        exp_wdata.delete();
        emit(enc_i(data_base[11:0], 5'd0, 3'b000, 5'd10, 7'h13));
    endtask

    task automatic start_program();
        @(posedge clk_cpu);
        #0.5;
        rst_n = 1'b0;
        repeat (2) @(posedge clk_cpu);
        #0.5;
        for (int i = 0; i < 1024; i++) begin
            i_mem.mem[i] = (i < prog.size()) ? prog[i] : fill_word(i);
        end
        foreach (pre_addr[i]) begin
            i_mem.mem[pre_addr[i][11:2]] = pre_val[i];
        end
        seen_lens.delete();
        seen_wdata.delete();
        fetch_count = 0;
        loop_seen   = 1'b0;
        have_last   = 1'b0;
        first_req   = 1'b1;
        rst_n       = 1'b1;
    endtask

    task automatic run_program();
        start_program();
        while (!loop_seen) @(posedge clk_cpu);
    endtask

    task automatic check_results();
        foreach (exp_vals[i]) begin
            check_word($sformatf("mem[%h]", exp_addr[i]), i_mem.mem[exp_addr[i][11:2]],
                       exp_vals[i]);
        end
    endtask

    // ====================
    // directed tests
    // ====================
    task automatic build_alu_program();
        xword_t a;
        xword_t b;
        a = 32'h8765_4321;
        b = 32'h1234_5685;
        new_program();
        load_imm(5'd1, a);
        load_imm(5'd2, b);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b000, 3), 3, a + b);
        emit_and_store(enc_r(7'h20, 2, 1, 3'b000, 3), 3, a - b);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b001, 3), 3, a << b[4:0]);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b010, 3), 3, {31'b0, $signed(a) < $signed(b)});
        emit_and_store(enc_r(7'h00, 2, 1, 3'b011, 3), 3, {31'b0, a < b});
        emit_and_store(enc_r(7'h00, 2, 1, 3'b100, 3), 3, a ^ b);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b101, 3), 3, a >> b[4:0]);
        emit_and_store(enc_r(7'h20, 2, 1, 3'b101, 3), 3, $signed(a) >>> b[4:0]);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b110, 3), 3, a | b);
        emit_and_store(enc_r(7'h00, 2, 1, 3'b111, 3), 3, a & b);
        // immediate forms
        emit_and_store(enc_i(12'hffb, 1, 3'b000, 3, 7'h13), 3, a - 5);
        emit_and_store(enc_i(12'h5a5, 1, 3'b100, 3, 7'h13), 3, a ^ 32'h5a5);
        emit_and_store(enc_i(12'h80f, 1, 3'b110, 3, 7'h13), 3, a | 32'hffff_f80f);
        emit_and_store(enc_i(12'h0f0, 1, 3'b111, 3, 7'h13), 3, a & 32'hf0);
        emit_and_store(enc_i(12'h007, 1, 3'b001, 3, 7'h13), 3, a << 7);
        emit_and_store(enc_i(12'h009, 1, 3'b101, 3, 7'h13), 3, a >> 9);
        emit_and_store(enc_i(12'h409, 1, 3'b101, 3, 7'h13), 3, $signed(a) >>> 9);
        emit_and_store(enc_i(12'hfff, 1, 3'b010, 3, 7'h13), 3, {31'b0, $signed(a) < -1});
        emit_and_store(enc_i(12'hfff, 1, 3'b011, 3, 7'h13), 3, {31'b0, a < 32'hffff_ffff});
        emit(enc_j(0, 5'd0));
    endtask

    task automatic test_alu();
        build_alu_program();
        run_program();
        check_results();
    endtask

    task automatic test_loads();
        xword_t     w;
        logic [7:0]  bt;
        logic [15:0] hw;
        w = 32'h80f1_7f82;
        new_program();
        pre_addr.push_back(32'h600);
        pre_val.push_back(w);
        emit(enc_i(12'h600, 5'd0, 3'b000, 5'd11, 7'h13));
        for (int off = 0; off < 4; off++) begin
            bt = w[8*off +: 8];
            emit_and_store(enc_i(off, 11, 3'b000, 4, 7'h03), 4, {{24{bt[7]}}, bt});
            emit_and_store(enc_i(off, 11, 3'b100, 4, 7'h03), 4, {24'b0, bt});
        end
        for (int off = 0; off < 4; off += 2) begin
            hw = w[8*off +: 16];
            emit_and_store(enc_i(off, 11, 3'b001, 4, 7'h03), 4, {{16{hw[15]}}, hw});
            emit_and_store(enc_i(off, 11, 3'b101, 4, 7'h03), 4, {16'b0, hw});
        end
        emit_and_store(enc_i(0, 11, 3'b010, 4, 7'h03), 4, w);
        emit(enc_j(0, 5'd0));
        run_program();
        check_results();
    endtask

    task automatic test_stores();
        xword_t v;
        xword_t m;
        xword_t addr;
        v = 32'hc3d2_e1f0;
        new_program();
        load_imm(5'd1, v);
        for (int k = 0; k < 7; k++) begin
            // words 0-3 bytes, 4-5 halves, 6 whole word
            addr = data_base + 4*k + ((k < 4) ? k : (k == 5) ? 2 : 0);
            m = fill_word(addr[11:2]);
            if (k < 4) begin
                emit(enc_s(addr - data_base, 1, 10, 3'b000));
                m[8*addr[1:0] +: 8] = v[7:0];
                exp_lens.push_back(write_8);
                exp_wdata.push_back({4{v[7:0]}});
            end else if (k < 6) begin
                emit(enc_s(addr - data_base, 1, 10, 3'b001));
                m[16*addr[1] +: 16] = v[15:0];
                exp_lens.push_back(write_16);
                exp_wdata.push_back({2{v[15:0]}});
            end else begin
                emit(enc_s(addr - data_base, 1, 10, 3'b010));
                m = v;
                exp_lens.push_back(write_32);
                exp_wdata.push_back(v);
            end
            exp_vals.push_back(m);
            exp_addr.push_back(addr & ~32'd3);
        end
        emit(enc_j(0, 5'd0));
        run_program();
        check_results();
        if (seen_lens.size() != exp_lens.size()) begin
            $display("store test saw %0d writes on the bus instead of %0d",
                     seen_lens.size(), exp_lens.size());
            errors++;
        end else begin
            foreach (exp_lens[i]) begin
                check_len($sformatf("bus_len[%0d]", i), seen_lens[i], exp_lens[i]);
                check_word($sformatf("bus_wdata[%0d]", i), seen_wdata[i], exp_wdata[i]);
            end
        end
    endtask

    task automatic branch_case(input logic [2:0] f3, input reg_idx_t rs1, input reg_idx_t rs2,
                               input logic taken);
        emit(enc_i(12'd1, 0, 3'b000, 5, 7'h13));
        emit(enc_b(8, rs2, rs1, f3));
        emit(enc_i(12'd2, 0, 3'b000, 5, 7'h13));
        store_expect(5, taken ? 32'd1 : 32'd2);
    endtask

    task automatic test_branches();
        xword_t p;
        logic [2:0] conds [6];
        logic [2:0] taken [6];
        conds = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
        // outcome for the pairs (5,5), (5,-3) and (-3,5), msb first
        taken = '{3'b100, 3'b011, 3'b001, 3'b110, 3'b010, 3'b101};
        new_program();
        emit(enc_i(12'd5, 0, 3'b000, 1, 7'h13));
        emit(enc_i(12'hffd, 0, 3'b000, 2, 7'h13));
        emit(enc_i(12'd5, 0, 3'b000, 3, 7'h13));
        foreach (conds[i]) begin
            branch_case(conds[i], 1, 3, taken[i][2]);
            branch_case(conds[i], 1, 2, taken[i][1]);
            branch_case(conds[i], 2, 1, taken[i][0]);
        end
        p = pc_now();
        emit(enc_j(8, 5'd6));
        emit(enc_i(12'd1, 0, 3'b000, 7, 7'h13));
        store_expect(6, p + 4);
        store_expect(7, 0);
        // odd target, bit 0 must be dropped
        p = pc_now();
        emit(enc_i(p + 13, 0, 3'b000, 8, 7'h13));
        emit(enc_i(0, 8, 3'b000, 9, 7'h67));
        emit(enc_i(12'd3, 0, 3'b000, 7, 7'h13));
        store_expect(9, p + 8);
        store_expect(7, 0);
        emit(enc_j(0, 5'd0));
        run_program();
        check_results();
    endtask

    task automatic test_upper();
        xword_t p;
        new_program();
        emit({20'habcde, 5'd1, 7'h37});
        store_expect(1, 32'habcd_e000);
        p = pc_now();
        emit({20'h12345, 5'd2, 7'h17});
        store_expect(2, p + 32'h1234_5000);
        p = pc_now();
        emit({20'hfffff, 5'd3, 7'h17});
        store_expect(3, p + 32'hffff_f000);
        emit(enc_j(0, 5'd0));
        run_program();
        check_results();
    endtask

    task automatic test_reset_and_stall();
        build_alu_program();
        start_program();
        while (fetch_count < 8) @(posedge clk_cpu);
        // second start resets the core mid program
        run_program();
        check_results();
        saved.delete();
        foreach (exp_addr[i]) begin
            saved.push_back(i_mem.mem[exp_addr[i][11:2]]);
        end
        fixed_lat = 12;
        run_program();
        check_results();
        foreach (saved[i]) begin
            check_word($sformatf("slow mem[%h]", exp_addr[i]), i_mem.mem[exp_addr[i][11:2]],
                       saved[i]);
        end
        fixed_lat = 0;
    endtask

    initial begin
        rst_n       = 1'b0;
        fixed_lat   = 0;
        fetch_count = 0;
        loop_seen   = 1'b0;
        have_last   = 1'b0;
        first_req   = 1'b0;
        last_fetch  = '0;
        test_alu();
        test_loads();
        test_stores();
        test_branches();
        test_upper();
        test_reset_and_stall();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

//--- files.f
common/rv_core_pkg.sv
hw/rv_decoder.sv
hw/reg_file.sv
hw/rv_alu.sv
hw/mem_access.sv
core/rv_control.sv
core/rv_core.sv
verif/tb_mem_model.sv
verif/tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - common/rv_core_pkg.sv
  - hw/rv_decoder.sv
  - hw/reg_file.sv
  - hw/rv_alu.sv
  - hw/mem_access.sv
  - core/rv_control.sv
  - core/rv_core.sv
  - target: simulation
    files:
      - verif/tb_mem_model.sv
      - verif/tb_rv_core.sv
